/* design/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define DATA_W    32
`define REG_COUNT 16
`define RESET_PC  32'h0000_0000
`define DATA_BASE 32'h0000_1000  // load/store region offset by imm16[11:0]

`endif

/* design/cpu_pkg.sv */
package cpu_pkg;

  // codes past op_halt run as nop
  typedef enum logic [5:0] {
    op_nop, op_add, op_sub, op_and, op_or, op_xor, op_shl, op_shr,
    op_addi, op_ldi, op_ldiu, op_mov, op_neg, op_not,
    op_ldl, op_ldw, op_ldb, op_stl, op_stw, op_stb,
    op_bra, op_beq, op_bne, op_blt, op_halt
  } opcode_e;

  typedef enum logic [2:0] {
    st_fetch, st_decode, st_execute, st_mem, st_writeback, st_halted
  } state_e;

  typedef enum logic [2:0] {
    alu_pass, alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_shl, alu_shr
  } alu_func_e;

  typedef enum logic [1:0] {pc_hold, pc_plus4, pc_branch} pc_sel_e;
  typedef enum logic [1:0] {mdr_hold, mdr_bus, mdr_reg} mdr_sel_e;

  typedef enum logic [2:0] {
    reg_alu, reg_mdr, reg_neg, reg_inv, reg_move, reg_imm_sext, reg_imm_zext
  } reg_sel_e;

  typedef struct packed {
    logic [1:0]  spare;
    opcode_e     opcode;
    logic [3:0]  rd;
    logic [3:0]  ra;
    logic [15:0] imm16;  // rb is the top nibble
  } instr_t;

  typedef struct packed {
    logic carry;
    logic negative;
    logic overflow;
    logic zero;
  } flags_t;

  typedef struct packed {
    pc_sel_e    pc_sel;
    logic       mar_sel;     // latch data address
    mdr_sel_e   mdr_sel;
    alu_func_e  alu_func;
    logic       alu2_sel;    // immediate operand
    reg_sel_e   reg_sel;
    logic       reg_write;
    logic       ir_write;
    logic       flags_write;
    logic       addr_sel;    // bus address from mar
    logic [3:0] byteenable;
    logic       read;
    logic       write;
  } ctrl_t;

endpackage

/* design/cpu_regfile.sv */
`include "cpu_params.svh"

module cpu_regfile (
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic [$clog2(`REG_COUNT)-1:0] read_addr1,
  input  logic [$clog2(`REG_COUNT)-1:0] read_addr2,
  input  logic [$clog2(`REG_COUNT)-1:0] write_addr,
  input  logic [`DATA_W-1:0]            write_data,
  input  logic                          write_en,
  output logic [`DATA_W-1:0]            data1,
  output logic [`DATA_W-1:0]            data2
);

  logic [`DATA_W-1:0] regs [`REG_COUNT];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en) begin
      regs[write_addr] <= write_data;
    end
  end

  // old value while the same register is being written
  assign data1 = regs[read_addr1];
  assign data2 = regs[read_addr2];

endmodule

/* design/cpu_alu.sv */
`include "cpu_params.svh"

module cpu_alu import cpu_pkg::*; (
  input  logic [`DATA_W-1:0] in1,
  input  logic [`DATA_W-1:0] in2,
  input  alu_func_e          func,
  output logic [`DATA_W-1:0] result,
  output flags_t             flags
);

  localparam int msb = `DATA_W - 1;

  logic [`DATA_W:0] sum;
  logic             carry;
  logic             overflow;

  always_comb begin
    sum      = '0;
    carry    = 1'b0;
    overflow = 1'b0;
    case (func)
      alu_add: begin
        sum      = {1'b0, in1} + {1'b0, in2};
        result   = sum[msb:0];
        carry    = sum[`DATA_W];
        overflow = (in1[msb] == in2[msb]) && (result[msb] != in1[msb]);
      end
      alu_sub: begin
        sum      = {1'b0, in1} - {1'b0, in2};
        result   = sum[msb:0];
        carry    = sum[`DATA_W];  // borrow
        overflow = (in1[msb] != in2[msb]) && (result[msb] != in1[msb]);
      end
      alu_and: result = in1 & in2;
      alu_or:  result = in1 | in2;
      alu_xor: result = in1 ^ in2;
      alu_shl: result = in1 << in2[4:0];
      alu_shr: result = in1 >> in2[4:0];  // logical
      default: result = in1;
    endcase
  end

  assign flags = '{
    carry:    carry,
    negative: result[msb],
    overflow: overflow,
    zero:     (result == '0)
  };

endmodule

/* design/cpu_control.sv */
module cpu_control import cpu_pkg::*; (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       waitrequest,
  input  instr_t     ir,
  input  flags_t     flags,
  input  logic [1:0] addr_low,
  output ctrl_t      ctrl,
  output logic       halted
);

  state_e     state;
  state_e     next_state;
  logic       running;  // low only in the cycle reset is released
  logic       taken;
  logic       is_load;
  logic       is_store;
  logic [3:0] lanes;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state   <= st_fetch;
      running <= 1'b0;
    end else begin
      state   <= next_state;
      running <= 1'b1;
    end
  end

  assign is_load  = ir.opcode inside {op_ldl, op_ldw, op_ldb};
  assign is_store = ir.opcode inside {op_stl, op_stw, op_stb};
  assign halted   = (state == st_halted);

  always_comb begin
    case (ir.opcode)
      op_bra:  taken = 1'b1;
      op_beq:  taken = flags.zero;
      op_bne:  taken = !flags.zero;
      op_blt:  taken = flags.negative ^ flags.overflow;  // signed less than
      default: taken = 1'b0;
    endcase
  end

  // little-endian lanes from size and offset
  always_comb begin
    case (ir.opcode)
      op_ldw, op_stw: lanes = addr_low[1] ? 4'b1100 : 4'b0011;
      op_ldb, op_stb: lanes = 4'b0001 << addr_low;
      default:        lanes = 4'b1111;
    endcase
  end

  always_comb begin
    ctrl            = '0;
    ctrl.pc_sel     = pc_hold;
    ctrl.mdr_sel    = mdr_hold;
    ctrl.byteenable = 4'b1111;
    ctrl.alu2_sel   = (ir.opcode == op_addi);
    next_state      = state;

    case (ir.opcode)
      op_add, op_addi: ctrl.alu_func = alu_add;
      op_sub:          ctrl.alu_func = alu_sub;
      op_and:          ctrl.alu_func = alu_and;
      op_or:           ctrl.alu_func = alu_or;
      op_xor:          ctrl.alu_func = alu_xor;
      op_shl:          ctrl.alu_func = alu_shl;
      op_shr:          ctrl.alu_func = alu_shr;
      default:         ctrl.alu_func = alu_pass;
    endcase

    case (ir.opcode)
      op_ldl, op_ldw, op_ldb: ctrl.reg_sel = reg_mdr;
      op_ldi:                 ctrl.reg_sel = reg_imm_sext;
      op_ldiu:                ctrl.reg_sel = reg_imm_zext;
      op_mov:                 ctrl.reg_sel = reg_move;
      op_neg:                 ctrl.reg_sel = reg_neg;
      op_not:                 ctrl.reg_sel = reg_inv;
      default:                ctrl.reg_sel = reg_alu;
    endcase

    case (state)
      st_fetch: begin
        ctrl.read     = running;
        ctrl.ir_write = running && !waitrequest;
        if (running && !waitrequest) begin
          next_state = st_decode;
        end
      end
      st_decode: begin
        ctrl.pc_sel = pc_plus4;
        next_state  = (ir.opcode == op_halt) ? st_halted : st_execute;
      end
      st_execute: begin
        next_state = st_fetch;
        case (ir.opcode)
          op_add, op_sub, op_and, op_or, op_xor, op_shl, op_shr, op_addi: begin
            ctrl.flags_write = 1'b1;
            next_state       = st_writeback;
          end
          op_ldi, op_ldiu, op_mov, op_neg, op_not: next_state = st_writeback;
          op_ldl, op_ldw, op_ldb, op_stl, op_stw, op_stb: begin
            ctrl.mar_sel = 1'b1;
            if (is_store) begin
              ctrl.mdr_sel = mdr_reg;
            end
            next_state = st_mem;
          end
          op_bra, op_beq, op_bne, op_blt: begin
            if (taken) begin
              ctrl.pc_sel = pc_branch;
            end
          end
          default: next_state = st_fetch;  // nop
        endcase
      end
      st_mem: begin
        ctrl.addr_sel   = 1'b1;
        ctrl.byteenable = lanes;
        ctrl.read       = is_load;
        ctrl.write      = is_store;
        if (!waitrequest) begin
          if (is_load) begin
            ctrl.mdr_sel = mdr_bus;
            next_state   = st_writeback;
          end else begin
            next_state = st_fetch;
          end
        end
      end
      st_writeback: begin
        ctrl.reg_write = 1'b1;
        next_state     = st_fetch;
      end
      st_halted: next_state = st_halted;  // until reset
      default:   next_state = st_fetch;
    endcase
  end

endmodule

/* design/cpu_core.sv */
`include "cpu_params.svh"

module cpu_core import cpu_pkg::*; (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               waitrequest,
  input  logic [`DATA_W-1:0] readdata,
  output logic [`DATA_W-1:0] address,
  output logic               read,
  output logic               write,
  output logic [`DATA_W-1:0] writedata,
  output logic [3:0]         byteenable,
  output logic               halted
);

  ctrl_t              ctrl;
  instr_t             ir;
  flags_t             ccr;
  flags_t             alu_flags;
  logic [`DATA_W-1:0] pc;
  logic [`DATA_W-1:0] mar;
  logic [`DATA_W-1:0] mdr;
  logic [`DATA_W-1:0] aluval;
  logic [`DATA_W-1:0] pc_next;
  logic [`DATA_W-1:0] mdr_next;
  logic [`DATA_W-1:0] busin_be;
  logic [`DATA_W-1:0] reg_data_in;
  logic [`DATA_W-1:0] reg_data1;
  logic [`DATA_W-1:0] reg_data2;
  logic [`DATA_W-1:0] alu_in2;
  logic [`DATA_W-1:0] alu_out;
  logic [`DATA_W-1:0] imm_sext;
  logic [`DATA_W-1:0] imm_zext;

  assign imm_sext = {{(`DATA_W-16){ir.imm16[15]}}, ir.imm16};
  assign imm_zext = {{(`DATA_W-16){1'b0}}, ir.imm16};

  assign address    = ctrl.addr_sel ? mar : pc;
  assign read       = ctrl.read;
  assign write      = ctrl.write;
  assign byteenable = ctrl.byteenable;
  assign alu_in2    = ctrl.alu2_sel ? imm_sext : reg_data2;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pc  <= `RESET_PC;
      ir  <= '0;
      ccr <= '0;
    end else begin
      pc <= pc_next;
      if (ctrl.ir_write) begin
        ir <= instr_t'(readdata);
      end
      if (ctrl.flags_write) begin
        ccr <= alu_flags;
      end
    end
  end

  always_ff @(posedge clk) begin
    mdr    <= mdr_next;
    aluval <= alu_out;  // execute result for writeback
    if (ctrl.mar_sel) begin
      mar <= `DATA_BASE + {{(`DATA_W-12){1'b0}}, ir.imm16[11:0]};
    end
  end

  always_comb begin
    case (ctrl.pc_sel)
      pc_plus4:  pc_next = pc + 'd4;
      pc_branch: pc_next = pc + {imm_sext[`DATA_W-3:0], 2'b00};  // word offset
      default:   pc_next = pc;
    endcase

    // store lanes and load alignment
    case (ctrl.byteenable)
      4'b0011: begin
        writedata = {16'h0000, mdr[15:0]};
        busin_be  = {{16{readdata[15]}}, readdata[15:0]};
      end
      4'b1100: begin
        writedata = {mdr[15:0], 16'h0000};
        busin_be  = {{16{readdata[31]}}, readdata[31:16]};
      end
      4'b0001: begin
        writedata = {24'h000000, mdr[7:0]};
        busin_be  = {{24{readdata[7]}}, readdata[7:0]};
      end
      4'b0010: begin
        writedata = {16'h0000, mdr[7:0], 8'h00};
        busin_be  = {{24{readdata[15]}}, readdata[15:8]};
      end
      4'b0100: begin
        writedata = {8'h00, mdr[7:0], 16'h0000};
        busin_be  = {{24{readdata[23]}}, readdata[23:16]};
      end
      4'b1000: begin
        writedata = {mdr[7:0], 24'h000000};
        busin_be  = {{24{readdata[31]}}, readdata[31:24]};
      end
      default: begin
        writedata = mdr;
        busin_be  = readdata;
      end
    endcase

    case (ctrl.mdr_sel)
      mdr_bus: mdr_next = busin_be;
      mdr_reg: mdr_next = reg_data1;  // store source is ra
      default: mdr_next = mdr;
    endcase

    case (ctrl.reg_sel)
      reg_mdr:      reg_data_in = mdr;
      reg_neg:      reg_data_in = -reg_data2;
      reg_inv:      reg_data_in = ~reg_data2;
      reg_move:     reg_data_in = reg_data2;
      reg_imm_sext: reg_data_in = imm_sext;
      reg_imm_zext: reg_data_in = imm_zext;
      default:      reg_data_in = aluval;
    endcase
  end

  cpu_control u_control (
    .clk         (clk),
    .reset_n     (reset_n),
    .waitrequest (waitrequest),
    .ir          (ir),
    .flags       (ccr),
    .addr_low    (mar[1:0]),
    .ctrl        (ctrl),
    .halted      (halted)
  );

  cpu_regfile u_regfile (
    .clk        (clk),
    .reset_n    (reset_n),
    .read_addr1 (ir.ra),
    .read_addr2 (ir.imm16[15:12]),  // rb
    .write_addr (ir.rd),
    .write_data (reg_data_in),
    .write_en   (ctrl.reg_write),
    .data1      (reg_data1),
    .data2      (reg_data2)
  );

  cpu_alu u_alu (
    .in1    (reg_data1),
    .in2    (alu_in2),
    .func   (ctrl.alu_func),
    .result (alu_out),
    .flags  (alu_flags)
  );

endmodule

/* tests/cpu_assert.sv */
module cpu_assert (
  input logic        clk,
  input logic        reset_n,
  input logic        waitrequest,
  input logic [31:0] address,
  input logic        read,
  input logic        write,
  input logic [31:0] writedata,
  input logic [3:0]  byteenable,
  input logic        halted
);
  timeunit 1ns;
  timeprecision 1ps;

  assert property (@(posedge clk) disable iff (!reset_n) !(read && write))
    else $error("read and write high together");

  // held request under back-pressure
  assert property (@(posedge clk) disable iff (!reset_n)
    (read || write) && waitrequest |=> $stable(address) && $stable(byteenable)
      && $stable(read) && $stable(write) && (!write || $stable(writedata)))
    else $error("bus request changed while waitrequest was high");

  assert property (@(posedge clk) disable iff (!reset_n)
    byteenable inside {4'b1111, 4'b0011, 4'b1100, 4'b0001, 4'b0010, 4'b0100, 4'b1000})
    else $error("illegal byteenable pattern");

  assert property (@(posedge clk) disable iff (!reset_n) halted |-> !read && !write)
    else $error("bus transfer while halted");

endmodule

/* tests/cpu_tb.sv */
`include "cpu_params.svh"

module cpu_tb import cpu_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_prog       = 4;
  localparam int prog_len     = 60;
  localparam int n_rand       = prog_len - 17;  // 16 final stores and a halt
  localparam int clk_period   = 40;
  localparam int reset_cycles = 16;
  localparam longint watchdog_ns = longint'(n_prog) * 70 * 12 * clk_period
                                   + n_prog * (reset_cycles + 10) * clk_period;

  typedef struct packed {
    logic [31:0] addr;
    logic [3:0]  be;
    logic [31:0] data;
  } store_t;

  logic        clk;
  logic        reset_n;
  logic        waitrequest;
  logic [31:0] readdata;
  logic [31:0] address;
  logic        read;
  logic        write;
  logic [31:0] writedata;
  logic [3:0]  byteenable;
  logic        halted;

  logic [31:0] rng = 32'd50459;
  logic [31:0] bus_mem [logic [31:0]];
  logic [31:0] model_mem [logic [31:0]];
  store_t      exp_q [$];
  int          value_errs = 0;
  int          other_errs = 0;
  bit          pending = 0;
  int          waits = 0;
  bit          first_read = 0;

  cpu_core uut (
    .clk         (clk),
    .reset_n     (reset_n),
    .waitrequest (waitrequest),
    .readdata    (readdata),
    .address     (address),
    .read        (read),
    .write       (write),
    .writedata   (writedata),
    .byteenable  (byteenable),
    .halted      (halted)
  );

  bind cpu_core cpu_assert u_assert (
    .clk(clk), .reset_n(reset_n), .waitrequest(waitrequest), .address(address),
    .read(read), .write(write), .writedata(writedata), .byteenable(byteenable),
    .halted(halted)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int unsigned next_rand(input int unsigned n);
    rng = xorshift(rng);
    return rng % n;
  endfunction

  // unwritten data words scrambled by the full address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9E37_79B1) ^ 32'h5A3C_96E1;
  endfunction

  function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) res[8*i +: 8] = new_w[8*i +: 8];
    end
    return res;
  endfunction

  task automatic gen_program();
    opcode_e     op;
    logic [15:0] imm;
    logic [31:0] word;
    int unsigned lim;
    bus_mem.delete();
    model_mem.delete();
    for (int i = 0; i < prog_len; i++) begin
      if (i == prog_len - 1) begin
        word = {2'b00, op_halt, 24'h0};
      end else if (i >= n_rand) begin
        word = {2'b00, op_stl, 4'h0, 4'(i - n_rand), 16'h0F00 + 16'((i - n_rand) * 4)};
      end else begin
        op  = opcode_e'(next_rand(24));  // anything but halt
        imm = 16'(next_rand(65536));
        case (op)
          op_bra, op_beq, op_bne, op_blt: begin
            lim = (n_rand - i < 6) ? n_rand - i : 6;
            imm = 16'(next_rand(lim));  // forward and never past the final stores
          end
          op_ldl, op_stl: imm = 16'(next_rand(64) * 4);
          op_ldw, op_stw: imm = 16'(next_rand(128) * 2);
          op_ldb, op_stb: imm = 16'(next_rand(256));
          default: ;
        endcase
        word = {2'b00, op, 4'(next_rand(16)), 4'(next_rand(16)), imm};
      end
      bus_mem[32'(i * 4)]   = word;
      model_mem[32'(i * 4)] = word;
    end
  endtask

  task automatic run_model();
    logic [31:0] r [16];
    logic [31:0] pc, npc, instr, a, b, bv, simm, res, ea, word, wa;
    logic [32:0] wide;
    logic        fc, fn, fv, fz, nc, nv, wr, setf, taken, done;
    opcode_e     op;
    store_t      st;
    for (int i = 0; i < 16; i++) r[i] = '0;
    {fc, fn, fv, fz} = '0;
    pc   = `RESET_PC;
    done = 0;
    for (int step = 0; step < 1000 && !done; step++) begin
      instr = model_mem[pc];
      op    = opcode_e'(instr[29:24]);
      a     = r[instr[19:16]];
      b     = r[instr[15:12]];
      simm  = {{16{instr[15]}}, instr[15:0]};
      ea    = `DATA_BASE + {20'h0, instr[11:0]};
      wa    = {ea[31:2], 2'b00};
      word  = model_mem.exists(wa) ? model_mem[wa] : fill_word(wa);
      npc   = pc + 4;
      {nc, nv} = '0;
      res   = '0;
      setf  = op inside {op_add, op_addi, op_sub, op_and, op_or, op_xor, op_shl, op_shr};
      wr    = setf || (op inside {op_ldi, op_ldiu, op_mov, op_neg, op_not,
                                  op_ldl, op_ldw, op_ldb});
      case (op)
        op_add, op_addi, op_sub: begin
          bv   = (op == op_addi) ? simm : b;
          wide = (op == op_sub) ? {1'b0, a} - {1'b0, bv} : {1'b0, a} + {1'b0, bv};
          res  = wide[31:0];
          nc   = wide[32];
          nv   = (op == op_sub) ? (a[31] != bv[31]) && (res[31] != a[31])
                                : (a[31] == bv[31]) && (res[31] != a[31]);
        end
        op_and:  res = a & b;
        op_or:   res = a | b;
        op_xor:  res = a ^ b;
        op_shl:  res = a << b[4:0];
        op_shr:  res = a >> b[4:0];
        op_ldi:  res = simm;
        op_ldiu: res = {16'h0, instr[15:0]};
        op_mov:  res = b;
        op_neg:  res = -b;
        op_not:  res = ~b;
        op_ldl:  res = word;
        op_ldw:  res = ea[1] ? {{16{word[31]}}, word[31:16]} : {{16{word[15]}}, word[15:0]};
        op_ldb: begin
          res = word >> (8 * ea[1:0]);
          res = {{24{res[7]}}, res[7:0]};
        end
        op_stl, op_stw, op_stb: begin
          st.addr = ea;
          if (op == op_stl) begin
            st.be   = 4'b1111;
            st.data = a;
          end else if (op == op_stw) begin
            st.be   = ea[1] ? 4'b1100 : 4'b0011;
            st.data = ea[1] ? {a[15:0], 16'h0} : {16'h0, a[15:0]};
          end else begin
            st.be   = 4'b0001 << ea[1:0];
            st.data = {24'h0, a[7:0]} << (8 * ea[1:0]);
          end
          model_mem[wa] = merge_lanes(word, st.data, st.be);
          exp_q.push_back(st);
        end
        op_bra, op_beq, op_bne, op_blt: begin
          taken = (op == op_bra) || (op == op_beq && fz) || (op == op_bne && !fz)
                  || (op == op_blt && (fn ^ fv));
          if (taken) npc = npc + {simm[29:0], 2'b00};
        end
        op_halt: done = 1;
        default: ;
      endcase
      if (wr) r[instr[23:20]] = res;
      if (setf) {fc, fn, fv, fz} = {nc, res[31], nv, res == '0};
      pc = npc;
    end
    assert (done) else begin
      $display("model never reached halt");
      other_errs++;
    end
  endtask

  task automatic check_write();
    store_t e;
    assert (exp_q.size() != 0) else begin
      $display("bus write at %h with no store left in the model", address);
      other_errs++;
    end
    if (exp_q.size() != 0) begin
      e = exp_q.pop_front();
      assert (address == e.addr) else begin
        $display("[FAIL] address exp %h got %h", e.addr, address);
        value_errs++;
      end
      assert (byteenable == e.be) else begin
        $display("[FAIL] byteenable exp %h got %h", e.be, byteenable);
        value_errs++;
      end
      assert (writedata == e.data) else begin
        $display("[FAIL] writedata exp %h got %h", e.data, writedata);
        value_errs++;
      end
    end
  endtask

  // bus memory responding on the falling edge
  always @(negedge clk) begin
    logic [31:0] wa;
    logic [31:0] cur;
    if (halted) begin
      assert (!read && !write) else begin
        $display("bus transfer requested after halt");
        other_errs++;
      end
    end
    if (first_read && read) begin
      assert (address == `RESET_PC) else begin
        $display("[FAIL] address exp %h got %h", `RESET_PC, address);
        value_errs++;
      end
      first_read = 0;
    end
    if (reset_n && (read || write)) begin
      if (!pending) begin
        pending = 1;
        waits   = next_rand(4);
      end
      if (waits > 0) begin
        waitrequest <= 1'b1;
        waits--;
      end else begin
        waitrequest <= 1'b0;
        pending = 0;
        wa  = {address[31:2], 2'b00};
        cur = bus_mem.exists(wa) ? bus_mem[wa] : fill_word(wa);
        if (read) begin
          readdata <= cur;
        end else begin
          check_write();
          bus_mem[wa] = merge_lanes(cur, writedata, byteenable);
        end
      end
    end else begin
      waitrequest <= 1'b0;
      pending = 0;
    end
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired before the core halted");
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    reset_n     = 1'b0;
    waitrequest = 1'b0;
    readdata    = '0;
    for (int p = 0; p < n_prog; p++) begin
      @(negedge clk);
      reset_n = 1'b0;
      exp_q.delete();
      gen_program();
      run_model();
      repeat (reset_cycles) @(negedge clk);
      assert (!read && !write && !halted) else begin
        $display("bus outputs not idle during reset");
        other_errs++;
      end
      first_read = 1;
      reset_n    = 1'b1;
      while (!halted) @(negedge clk);
      repeat (8) @(negedge clk);  // nothing may move after halt
      assert (exp_q.size() == 0) else begin
        $display("program %0d ended with %0d predicted stores missing", p, exp_q.size());
        other_errs++;
      end
    end
    $display("value errors %0d, other errors %0d", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+design
design/cpu_pkg.sv
design/cpu_regfile.sv
design/cpu_alu.sv
design/cpu_control.sv
design/cpu_core.sv
tests/cpu_assert.sv
tests/cpu_tb.sv

/* run.sh */
#!/bin/sh
# build and run the cpu testbench with Verilator

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module cpu_tb \
  --Mdir obj_dir -o cpu_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/cpu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
  exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
  echo "simulation ended without a verdict"
  exit 1
fi
exit 0
